/* Makefile */
SRCS := rtl/regfile_settings.svh rtl/regfile_pkg.sv rtl/accum_pipe.sv \
	rtl/register_bank.sv rtl/dispatch_router.sv rtl/regfile_top.sv \
	verification/regfile_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vregfile_tb: $(SRCS) files.f
	verilator --binary --timing --assert --top-module regfile_tb -f files.f

run: obj_dir/Vregfile_tb
	./obj_dir/Vregfile_tb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
+incdir+rtl
rtl/regfile_pkg.sv
rtl/accum_pipe.sv
rtl/register_bank.sv
rtl/dispatch_router.sv
rtl/regfile_top.sv
verification/regfile_tb.sv

/* rtl/accum_pipe.sv */
`include "regfile_settings.svh"

module accum_pipe (
	input logic clk,
	input logic reset,
	input regfile_pkg::acc_req_t req,
	output logic ready,
	input logic [31:0] base,
	output logic result_valid,
	output logic [31:0] result
);
	localparam int count_width = $clog2(`ACC_LATENCY) + 1;

	logic [count_width-1:0] count;
	logic accept;
	logic [31:0] operand_a;
	logic [31:0] sum_q;
	logic [31:0] delay_q[`ACC_LATENCY-1];

	// a new request may enter on the cycle the previous result is due.
	assign ready = count <= count_width'(1);
	assign accept = req.valid && ready;
	assign result_valid = count == count_width'(1);
	assign result = delay_q[`ACC_LATENCY-2];

	// take the in-flight sum, the register has not been written yet.
	assign operand_a = result_valid ? result : base;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (accept) begin
			count <= count_width'(`ACC_LATENCY);
		end else if (count != '0) begin
			count <= count - count_width'(1);
		end
	end

	// adder output register, then the remaining stages of the latency.
	always_ff @(posedge clk) begin
		sum_q <= operand_a + req.data;
		delay_q[0] <= sum_q;
		for (int i = 1; i < `ACC_LATENCY - 1; i++) begin
			delay_q[i] <= delay_q[i-1];
		end
	end

	// result pulse is a single cycle per accepted request.
	assert property (@(posedge clk) disable iff (reset)
		result_valid && !accept |=> !result_valid);

	// a waiting request holds still until the lane takes it.
	assert property (@(posedge clk) disable iff (reset)
		req.valid && !ready |=> req.valid && req.data == $past(req.data));

endmodule

/* rtl/dispatch_router.sv */
`include "regfile_settings.svh"

module dispatch_router (
	input regfile_pkg::inst_regs_t inst,
	input logic issue,
	input logic [`ROB_WIDTH-1:0] issue_tag,
	input regfile_pkg::commit_t commit,
	output logic gpr_issue,
	output logic fpr_issue,
	output regfile_pkg::commit_t gpr_commit,
	output regfile_pkg::commit_t fpr_commit,
	input regfile_pkg::reg_entry_t gpr_rd[2],
	input regfile_pkg::reg_entry_t fpr_rd[2],
	output regfile_pkg::reg_entry_t operands[2]
);
	logic [1:0] rd_fp;
	logic [1:0] fwd_hit;
	regfile_pkg::reg_entry_t picked[2];

	assign rd_fp = {inst.r2_fp, inst.r1_fp};

	// destination class picks the bank that sees the issue.
	assign gpr_issue = issue && !inst.r0_fp;
	assign fpr_issue = issue && inst.r0_fp;

	always_comb begin
		gpr_commit = commit;
		gpr_commit.valid = commit.valid && !commit.fp;
		fpr_commit = commit;
		fpr_commit.valid = commit.valid && commit.fp;
	end

	for (genvar i = 0; i < 2; i++) begin : g_operand
		assign picked[i] = rd_fp[i] ? fpr_rd[i] : gpr_rd[i];

		// same-cycle commit of the producer completes the operand.
		assign fwd_hit[i] = !picked[i].valid && commit.valid
			&& commit.fp == rd_fp[i] && commit.tag == picked[i].tag;

		always_comb begin
			operands[i] = picked[i];
			if (fwd_hit[i]) begin
				operands[i].valid = 1'b1;
				operands[i].data = commit.data;
			end
		end
	end

endmodule

/* rtl/regfile_pkg.sv */
`include "regfile_settings.svh"

package regfile_pkg;

	// one register entry, also the shape of an operand read.
	typedef struct packed {
		logic valid;
		logic [`ROB_WIDTH-1:0] tag;
		logic [31:0] data;
	} reg_entry_t;

	// register fields of the instruction at issue.
	typedef struct packed {
		logic [`REG_WIDTH-1:0] r0;
		logic [`REG_WIDTH-1:0] r1;
		logic [`REG_WIDTH-1:0] r2;
		logic r0_fp;
		logic r1_fp;
		logic r2_fp;
	} inst_regs_t;

	// commit from the reorder buffer, fp selects the bank.
	typedef struct packed {
		logic valid;
		logic [`REG_WIDTH-1:0] arch_num;
		logic fp;
		logic [`ROB_WIDTH-1:0] tag;
		logic [31:0] data;
	} commit_t;

	// accumulate request, transfers when valid and ready are both high.
	typedef struct packed {
		logic valid;
		logic [31:0] data;
	} acc_req_t;

endpackage

/* rtl/regfile_settings.svh */
`ifndef REGFILE_SETTINGS_SVH
`define REGFILE_SETTINGS_SVH

// architectural register index, 32 entries per bank.
`define REG_WIDTH 5

// reorder buffer tag.
`define ROB_WIDTH 4

// accumulator lanes at the top of the floating-point bank.
`define N_ACC 2

// cycles from an accepted request to the accumulator write.
`define ACC_LATENCY 6

`endif

/* rtl/regfile_top.sv */
`include "regfile_settings.svh"

module regfile_top (
	input logic clk,
	input logic reset,
	input regfile_pkg::inst_regs_t inst,
	input logic issue,
	input logic [`ROB_WIDTH-1:0] issue_tag,
	input regfile_pkg::commit_t commit,
	input regfile_pkg::acc_req_t acc_req[`N_ACC],
	output logic acc_ready[`N_ACC],
	output regfile_pkg::reg_entry_t operands[2]
);
	logic gpr_issue;
	logic fpr_issue;
	regfile_pkg::commit_t gpr_commit;
	regfile_pkg::commit_t fpr_commit;
	regfile_pkg::reg_entry_t gpr_rd[2];
	regfile_pkg::reg_entry_t fpr_rd[2];
	logic [`REG_WIDTH-1:0] rd_reg[2];
	regfile_pkg::acc_req_t gpr_acc_req[1];

	assign rd_reg[0] = inst.r1;
	assign rd_reg[1] = inst.r2;

	// integer bank has no accumulators, its request slot stays idle.
	assign gpr_acc_req[0] = '0;

	dispatch_router i_router (
		.inst(inst),
		.issue(issue),
		.issue_tag(issue_tag),
		.commit(commit),
		.gpr_issue(gpr_issue),
		.fpr_issue(fpr_issue),
		.gpr_commit(gpr_commit),
		.fpr_commit(fpr_commit),
		.gpr_rd(gpr_rd),
		.fpr_rd(fpr_rd),
		.operands(operands)
	);

	register_bank #(
		.num_acc(0)
	) i_gpr_bank (
		.clk(clk),
		.reset(reset),
		.issue(gpr_issue),
		.issue_tag(issue_tag),
		.issue_reg(inst.r0),
		.commit(gpr_commit),
		.rd_reg(rd_reg),
		.rd(gpr_rd),
		.acc_req(gpr_acc_req),
		.acc_ready()
	);

	register_bank #(
		.num_acc(`N_ACC)
	) i_fpr_bank (
		.clk(clk),
		.reset(reset),
		.issue(fpr_issue),
		.issue_tag(issue_tag),
		.issue_reg(inst.r0),
		.commit(fpr_commit),
		.rd_reg(rd_reg),
		.rd(fpr_rd),
		.acc_req(acc_req),
		.acc_ready(acc_ready)
	);

endmodule

/* rtl/register_bank.sv */
`include "regfile_settings.svh"

module register_bank #(
	parameter int num_acc = 0
) (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic [`ROB_WIDTH-1:0] issue_tag,
	input logic [`REG_WIDTH-1:0] issue_reg,
	input regfile_pkg::commit_t commit,
	input logic [`REG_WIDTH-1:0] rd_reg[2],
	output regfile_pkg::reg_entry_t rd[2],
	input regfile_pkg::acc_req_t acc_req[(num_acc == 0) ? 1 : num_acc],
	output logic acc_ready[(num_acc == 0) ? 1 : num_acc]
);
	localparam int n_entries = 2 ** `REG_WIDTH;
	localparam int n_lanes = (num_acc == 0) ? 1 : num_acc;
	// accumulators occupy the top entries.
	localparam int acc_base = n_entries - num_acc;

	regfile_pkg::reg_entry_t entries[n_entries];
	logic acc_valid[n_lanes];
	logic [31:0] acc_result[n_lanes];
	logic [n_entries-1:0] tag_busy;

	// operand reads are combinational.
	assign rd[0] = entries[rd_reg[0]];
	assign rd[1] = entries[rd_reg[1]];

	if (num_acc > 0) begin : g_lanes
		for (genvar j = 0; j < num_acc; j++) begin : g_lane
			accum_pipe i_accum_pipe (
				.clk(clk),
				.reset(reset),
				.req(acc_req[j]),
				.ready(acc_ready[j]),
				.base(entries[acc_base + j].data),
				.result_valid(acc_valid[j]),
				.result(acc_result[j])
			);
		end
	end else begin : g_no_lanes
		// no accumulators in this bank.
		assign acc_ready[0] = 1'b0;
		assign acc_valid[0] = 1'b0;
		assign acc_result[0] = 32'd0;
	end

	for (genvar i = 0; i < n_entries; i++) begin : g_entry
		regfile_pkg::reg_entry_t entry_q;
		logic issue_hit;
		logic tag_match;
		logic data_hit;
		logic acc_write;
		logic [31:0] acc_value;

		assign issue_hit = issue && issue_reg == `REG_WIDTH'(i);
		assign tag_match = commit.valid && entry_q.tag == commit.tag;
		// data lands only while the entry still waits.
		assign data_hit = commit.valid && !entry_q.valid
			&& commit.arch_num == `REG_WIDTH'(i);

		if (i >= acc_base) begin : g_acc
			assign acc_write = acc_valid[i - acc_base];
			assign acc_value = acc_result[i - acc_base];
		end else begin : g_plain
			assign acc_write = 1'b0;
			assign acc_value = 32'd0;
		end

		always_ff @(posedge clk) begin
			if (reset) begin
				entry_q.valid <= 1'b1;
				entry_q.data <= 32'd0;
			end else begin
				// issue beats commit on the valid bit.
				if (issue_hit) begin
					entry_q.valid <= 1'b0;
				end else if (tag_match) begin
					entry_q.valid <= 1'b1;
				end

				// accumulator write beats commit data.
				if (acc_write) begin
					entry_q.data <= acc_value;
				end else if (data_hit) begin
					entry_q.data <= commit.data;
				end
			end

			if (issue_hit) begin
				entry_q.tag <= issue_tag;
			end
		end

		assign entries[i] = entry_q;
		assign tag_busy[i] = !entry_q.valid && entry_q.tag == issue_tag;
	end

	// the ROB never hands out a tag that an entry still waits on.
	assert property (@(posedge clk) disable iff (reset)
		issue |-> tag_busy == '0);

endmodule

/* verification/regfile_tb.sv */
`include "regfile_settings.svh"

module regfile_tb;
	logic clk;
	logic reset;
	regfile_pkg::inst_regs_t inst;
	logic issue;
	logic [`ROB_WIDTH-1:0] issue_tag;
	regfile_pkg::commit_t commit;
	regfile_pkg::acc_req_t acc_req[`N_ACC];
	logic acc_ready[`N_ACC];
	regfile_pkg::reg_entry_t operands[2];

	int errors;
	int tests_run;
	int tests_bad;
	int cycles;
	// shadow of register data, index 0 integer bank, 1 floating-point bank.
	logic [31:0] model_data[2][2 ** `REG_WIDTH];

	regfile_top i_dut (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.issue(issue),
		.issue_tag(issue_tag),
		.commit(commit),
		.acc_req(acc_req),
		.acc_ready(acc_ready),
		.operands(operands)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > 2000) begin
			$display("timeout: the run did not finish within 2000 cycles");
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got %h expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_operand(int idx, logic valid, logic [`ROB_WIDTH-1:0] tag,
		logic [31:0] data, bit with_tag);
		string prefix;
		prefix = $sformatf("operands[%0d]", idx);
		check_value({prefix, ".valid"}, 32'(operands[idx].valid), 32'(valid));
		if (with_tag) begin
			check_value({prefix, ".tag"}, 32'(operands[idx].tag), 32'(tag));
		end
		check_value({prefix, ".data"}, operands[idx].data, data);
	endtask

	task automatic report_test(string name, int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// drives the read fields on the next rising edge.
	task automatic set_reads(int r1, bit fp1, int r2, bit fp2);
		@(posedge clk);
		inst.r1 <= `REG_WIDTH'(r1);
		inst.r1_fp <= fp1;
		inst.r2 <= `REG_WIDTH'(r2);
		inst.r2_fp <= fp2;
	endtask

	task automatic issue_reg(int r, bit fp, logic [`ROB_WIDTH-1:0] tag);
		@(posedge clk);
		inst.r0 <= `REG_WIDTH'(r);
		inst.r0_fp <= fp;
		issue <= 1'b1;
		issue_tag <= tag;
		@(posedge clk);
		issue <= 1'b0;
	endtask

	task automatic commit_reg(int r, bit fp, logic [`ROB_WIDTH-1:0] tag, logic [31:0] data);
		@(posedge clk);
		commit <= {1'b1, `REG_WIDTH'(r), fp, tag, data};
		@(posedge clk);
		commit <= '0;
	endtask

	// waits until the lane may accept, then lets one edge pass.
	task automatic wait_ready_edge(int lane);
		@(negedge clk);
		while (!acc_ready[lane]) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	// follows a lane from the edge that accepted a request up to the edge that writes the sum.
	task automatic check_busy_window(int lane, logic [31:0] old_value);
		for (int j = 0; j < `ACC_LATENCY; j++) begin
			@(negedge clk);
			check_value($sformatf("acc_ready[%0d]", lane), 32'(acc_ready[lane]),
				32'(j == `ACC_LATENCY - 1));
			check_value("operands[0].data", operands[0].data, old_value);
			@(posedge clk);
		end
	endtask

	task automatic test_reset();
		int e;
		e = errors;
		for (int b = 0; b < 2; b++) begin
			for (int i = 0; i < 2 ** `REG_WIDTH; i++) begin
				set_reads(i, b[0], 2 ** `REG_WIDTH - 1 - i, b[0]);
				@(negedge clk);
				check_operand(0, 1'b1, '0, 32'd0, 1'b0);
				check_operand(1, 1'b1, '0, 32'd0, 1'b0);
			end
		end
		for (int j = 0; j < `N_ACC; j++) begin
			check_value($sformatf("acc_ready[%0d]", j), 32'(acc_ready[j]), 32'd1);
		end
		report_test("reset", e);
	endtask

	task automatic test_issue_commit();
		int e;
		logic [`ROB_WIDTH-1:0] t1;
		logic [`ROB_WIDTH-1:0] t_stale;
		logic [31:0] d1;
		logic [31:0] d2;
		e = errors;
		t1 = `ROB_WIDTH'($urandom);
		t_stale = t1 + `ROB_WIDTH'(1);
		d1 = $urandom;
		d2 = $urandom;
		set_reads(5, 1'b0, 5, 1'b0);
		issue_reg(5, 1'b0, t1);
		@(negedge clk);
		check_operand(0, 1'b0, t1, model_data[0][5], 1'b1);
		// stale tag writes the data, the entry keeps waiting.
		commit_reg(5, 1'b0, t_stale, d1);
		model_data[0][5] = d1;
		@(negedge clk);
		check_operand(0, 1'b0, t1, model_data[0][5], 1'b1);
		commit_reg(5, 1'b0, t1, d2);
		model_data[0][5] = d2;
		@(negedge clk);
		check_operand(0, 1'b1, t1, d2, 1'b1);
		report_test("issue_commit", e);
	endtask

	task automatic test_forward();
		int e;
		logic [`ROB_WIDTH-1:0] t2;
		logic [31:0] d3;
		e = errors;
		t2 = `ROB_WIDTH'($urandom);
		d3 = $urandom;
		set_reads(7, 1'b1, 7, 1'b1);
		issue_reg(7, 1'b1, t2);
		@(negedge clk);
		check_operand(1, 1'b0, t2, model_data[1][7], 1'b1);
		@(posedge clk);
		commit <= {1'b1, `REG_WIDTH'(7), 1'b1, t2, d3};
		@(negedge clk);
		check_operand(0, 1'b1, t2, d3, 1'b0);
		check_operand(1, 1'b1, t2, d3, 1'b0);
		@(posedge clk);
		commit <= '0;
		model_data[1][7] = d3;
		@(negedge clk);
		check_operand(0, 1'b1, t2, d3, 1'b1);
		report_test("forward", e);
	endtask

	task automatic test_class_routing();
		int e;
		logic [`ROB_WIDTH-1:0] ta;
		logic [`ROB_WIDTH-1:0] tb;
		logic [31:0] da;
		logic [31:0] db;
		e = errors;
		ta = `ROB_WIDTH'($urandom);
		tb = ta + `ROB_WIDTH'(3);
		da = $urandom;
		db = $urandom;
		set_reads(9, 1'b0, 9, 1'b1);
		issue_reg(9, 1'b0, ta);
		issue_reg(9, 1'b1, tb);
		@(negedge clk);
		check_operand(0, 1'b0, ta, model_data[0][9], 1'b1);
		check_operand(1, 1'b0, tb, model_data[1][9], 1'b1);
		commit_reg(9, 1'b0, ta, da);
		model_data[0][9] = da;
		@(negedge clk);
		check_operand(0, 1'b1, ta, da, 1'b1);
		check_operand(1, 1'b0, tb, model_data[1][9], 1'b1);
		commit_reg(9, 1'b1, tb, db);
		model_data[1][9] = db;
		@(negedge clk);
		check_operand(0, 1'b1, ta, da, 1'b1);
		check_operand(1, 1'b1, tb, db, 1'b1);
		report_test("class_routing", e);
	endtask

	task automatic test_accumulate();
		int e;
		int acc_reg;
		logic [31:0] a;
		logic [31:0] b;
		e = errors;
		acc_reg = 2 ** `REG_WIDTH - `N_ACC;
		a = $urandom;
		b = $urandom;
		set_reads(acc_reg, 1'b1, acc_reg, 1'b1);
		@(posedge clk);
		acc_req[0] <= {1'b1, a};
		wait_ready_edge(0);
		acc_req[0] <= '0;
		check_busy_window(0, model_data[1][acc_reg]);
		model_data[1][acc_reg] = model_data[1][acc_reg] + a;
		@(negedge clk);
		check_operand(0, 1'b1, '0, model_data[1][acc_reg], 1'b0);

		// second request is held until accepted on the due cycle.
		@(posedge clk);
		acc_req[0] <= {1'b1, a};
		wait_ready_edge(0);
		acc_req[0] <= {1'b1, b};
		check_busy_window(0, model_data[1][acc_reg]);
		acc_req[0] <= '0;
		model_data[1][acc_reg] = model_data[1][acc_reg] + a;
		check_busy_window(0, model_data[1][acc_reg]);
		model_data[1][acc_reg] = model_data[1][acc_reg] + b;
		@(negedge clk);
		check_operand(0, 1'b1, '0, model_data[1][acc_reg], 1'b0);
		report_test("accumulate", e);
	endtask

	task automatic test_priority();
		int e;
		int acc_reg;
		logic [`ROB_WIDTH-1:0] tp;
		logic [31:0] c;
		e = errors;
		acc_reg = 2 ** `REG_WIDTH - 1;
		tp = `ROB_WIDTH'($urandom);
		c = $urandom;
		set_reads(acc_reg, 1'b1, acc_reg, 1'b1);
		issue_reg(acc_reg, 1'b1, tp);
		@(posedge clk);
		acc_req[1] <= {1'b1, c};
		wait_ready_edge(1);
		acc_req[1] <= '0;
		repeat (`ACC_LATENCY - 1) @(posedge clk);
		commit <= {1'b1, `REG_WIDTH'(acc_reg), 1'b1, tp, ~c};
		@(negedge clk);
		check_value("acc_ready[1]", 32'(acc_ready[1]), 32'd1);
		@(posedge clk);
		commit <= '0;
		model_data[1][acc_reg] = model_data[1][acc_reg] + c;
		@(negedge clk);
		check_operand(0, 1'b1, tp, model_data[1][acc_reg], 1'b1);
		report_test("priority", e);
	endtask

	initial begin
		void'($urandom(32'h7b64_bfd2));
		errors = 0;
		tests_run = 0;
		tests_bad = 0;
		cycles = 0;
		reset = 1'b1;
		inst = '0;
		issue = 1'b0;
		issue_tag = '0;
		commit = '0;
		for (int j = 0; j < `N_ACC; j++) begin
			acc_req[j] = '0;
		end
		for (int b = 0; b < 2; b++) begin
			for (int i = 0; i < 2 ** `REG_WIDTH; i++) begin
				model_data[b][i] = 32'd0;
			end
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		test_reset();
		test_issue_commit();
		test_forward();
		test_class_routing();
		test_accumulate();
		test_priority();

		$display("%0d tests, %0d with errors, %0d errors in total",
			tests_run, tests_bad, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
